// ==== bench/uart_stimulus.txt ====
# op offset data expected, all hex; wait: data is the LSR mask, expected the masked value
# send/recv: data is the byte count; inj: data is the character, expected 1 flips parity
rd   5 00 60
iir  0 00 01
rd   3 00 00
evt  0 00 00
txl  0 00 01
wr   3 80 00
wr   0 5a 00
wr   1 a5 00
rd   0 00 5a
rd   1 00 a5
wr   0 10 00
wr   1 00 00
wr   3 03 00
rd   1 00 00
err  6 00 01
err  2 00 00
loop 0 01 00
send 0 04 00
recv 0 04 00
wr   3 1e 00
send 0 04 00
recv 0 04 00
wr   3 08 00
send 0 04 00
recv 0 04 00
loop 0 00 00
wr   3 1b 00
wr   1 04 00
inj  0 a7 01
wait 0 01 01
rd   5 00 65
iir  0 00 06
evt  0 00 01
rd   0 00 a7
rd   5 00 60
evt  0 00 00
loop 0 01 00
wr   3 03 00
wr   2 40 00
wr   1 01 00
send 0 03 00
evt  0 00 00
send 0 01 00
evt  0 00 01
iir  0 00 04
wr   2 42 00
rd   5 00 60
evt  0 00 00

// ==== bench/uart_tb.sv ====
/*
 * uart testbench
 * reads APB commands from the stimulus file, runs random characters
 * through TX and RX in loopback or bit-bangs raw frames into rx_i,
 * then compares register reads, IIR codes and line levels
 */
`timescale 1ns/1ns

module uart_tb;

  localparam int WAIT_POLLS = 400;      // LSR polls per wait of 3 cycles each

  logic                 CLK;
  logic                 RSTN;
  logic [2:0]           paddr;
  logic [7:0]           pwdata;
  logic                 pwrite;
  logic                 psel;
  logic                 penable;
  logic [7:0]           prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 rx_line;
  logic                 tx_line;
  logic                 event_line;
  logic                 loop_mode;      // rx_i follows tx_o
  logic                 inj_line;       // bit-banged frame level
  logic [7:0]           lcr_sh;         // shadow of the last LCR write
  logic [7:0]           dll_sh;
  logic [7:0]           dlm_sh;
  uart_line_pkg::char_t exp_q[$];       // sent and not yet read back
  int                   check_count;

  uart_apb UUT (
    .CLK(CLK), .RSTN(RSTN), .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite),
    .psel_i(psel), .penable_i(penable), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .rx_i(rx_line), .tx_o(tx_line), .event_o(event_line)
  );

  assign rx_line = loop_mode ? tx_line : inj_line;

  always #10 CLK = ~CLK;                // 20 ns period

  //////////////////////////////////////////////////
  // failure reporting and compares

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input uart_line_pkg::char_t got, input uart_line_pkg::char_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s is %02h, expected %02h", $time, what, got, exp));
    end
    check_count++;
  endtask

  task automatic check_iir(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: IIR code is %01h, expected %01h", $time, got, exp));
    end
    check_count++;
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
    check_count++;
  endtask

  //////////////////////////////////////////////////
  // APB master with one idle cycle between accesses

  task automatic apb_write(input logic [2:0] addr, input logic [7:0] data);
    @(posedge CLK);
    #2;
    paddr  = addr;                      // setup phase
    pwdata = data;
    pwrite = 1'b1;
    psel   = 1'b1;
    @(posedge CLK);
    #2;
    penable = 1'b1;                     // access phase
    @(posedge CLK);                     // write lands here
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [2:0] addr, output logic [7:0] data, output logic err);
    @(posedge CLK);
    #2;
    paddr  = addr;
    pwrite = 1'b0;
    psel   = 1'b1;
    @(posedge CLK);
    #2;
    penable = 1'b1;
    #8;
    data = prdata;                      // sampled mid access phase
    err  = pslverr;
    check_bit(pready, 1'b1, "pready_o");  // no wait states
    @(posedge CLK);                     // RBR pop happens here
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_lsr(input logic [7:0] mask, input logic [7:0] value, input string what);
    logic [7:0] v;
    logic       e;
    int         polls;
    polls = 0;
    apb_read(uart_reg_pkg::ADR_LSR, v, e);
    while ((v & mask) != value) begin
      polls++;
      if (polls > WAIT_POLLS) begin
        abort_run($sformatf("timed out waiting for %s", what));
      end
      apb_read(uart_reg_pkg::ADR_LSR, v, e);
    end
  endtask

  //////////////////////////////////////////////////
  // line model from the LCR shadow

  function automatic uart_line_pkg::char_t word_mask(input logic [7:0] lcr);
    uart_line_pkg::char_t m;
    m = '0;
    for (int i = 0; i < 5 + lcr[1:0]; i++) begin
      m[i] = 1'b1;                      // one bit per data bit
    end
    return m;
  endfunction

  function automatic logic frame_parity(input uart_line_pkg::char_t d, input logic even);
    return even ? ^d : ~^d;             // even parity keeps the count of ones even
  endfunction

  task automatic track_write(input logic [2:0] addr, input logic [7:0] data);
    if (addr == uart_reg_pkg::ADR_LCR) begin
      lcr_sh = data;
    end else if (addr == uart_reg_pkg::ADR_RBR_THR && lcr_sh[uart_reg_pkg::LCR_DLAB]) begin
      dll_sh = data;
    end else if (addr == uart_reg_pkg::ADR_IER && lcr_sh[uart_reg_pkg::LCR_DLAB]) begin
      dlm_sh = data;
    end else if (addr == uart_reg_pkg::ADR_IIR_FCR && data[1]) begin
      exp_q.delete();                   // RX FIFO flushed
    end
  endtask

  task automatic send_bytes(input int count);
    uart_line_pkg::char_t b;
    repeat (count) begin
      b = 8'($urandom);
      exp_q.push_back(b & word_mask(lcr_sh));
      apb_write(uart_reg_pkg::ADR_RBR_THR, b);
      wait_lsr(8'h01 << uart_reg_pkg::LSR_TEMT, 8'h00, "the transmitter to start");
      wait_lsr(8'h01 << uart_reg_pkg::LSR_TEMT, 8'h01 << uart_reg_pkg::LSR_TEMT,
               "the transmitter to finish its frame");
    end
  endtask

  task automatic recv_bytes(input int count);
    logic [7:0] v;
    logic       e;
    repeat (count) begin
      wait_lsr(8'h01 << uart_reg_pkg::LSR_DR, 8'h01 << uart_reg_pkg::LSR_DR,
               "a received character");
      apb_read(uart_reg_pkg::ADR_RBR_THR, v, e);
      if (exp_q.size() == 0) begin
        abort_run("a character was received that was never sent");
      end
      check_byte(v, exp_q.pop_front(), "loopback RBR");
      apb_read(uart_reg_pkg::ADR_LSR, v, e);
      check_bit(v[uart_reg_pkg::LSR_PE], 1'b0, "LSR parity error");
    end
  endtask

  // start, data LSB first, parity and stop bits of div cycles each
  task automatic inject_frame(input uart_line_pkg::char_t data, input logic flip);
    logic [11:0]          bits;
    int                   nb;
    int                   nframe;
    int                   div;
    uart_line_pkg::char_t dm;
    nb      = 5 + lcr_sh[1:0];
    dm      = data & word_mask(lcr_sh);
    div     = {dlm_sh, dll_sh};
    bits    = '1;                       // stop bits and idle
    bits[0] = 1'b0;
    for (int i = 0; i < nb; i++) begin
      bits[i + 1] = dm[i];
    end
    nframe = 1 + nb + (lcr_sh[uart_reg_pkg::LCR_STOP] ? 2 : 1);
    if (lcr_sh[uart_reg_pkg::LCR_PEN]) begin
      bits[nb + 1] = frame_parity(dm, lcr_sh[uart_reg_pkg::LCR_EPS]) ^ flip;
      nframe++;
    end
    for (int i = 0; i < nframe; i++) begin
      @(posedge CLK);
      #2;
      inj_line = bits[i];
      repeat (div - 1) @(posedge CLK);
    end
  endtask

  //////////////////////////////////////////////////
  // one stimulus line

  task automatic run_op(input logic [63:0] op, input logic [7:0] off,
                        input logic [7:0] data, input logic [7:0] exp);
    logic [7:0] v;
    logic       e;
    case (op)
      "wr": begin
        track_write(off[2:0], data);
        apb_write(off[2:0], data);
      end
      "rd": begin
        apb_read(off[2:0], v, e);
        check_byte(v, exp, $sformatf("read of offset %0d", off));
      end
      "iir": begin
        apb_read(uart_reg_pkg::ADR_IIR_FCR, v, e);
        check_bit(&v[7:6], 1'b1, "IIR FIFO bits");
        check_iir(v[3:0], exp[3:0]);
      end
      "err": begin
        apb_read(off[2:0], v, e);
        check_bit(e, exp[0], $sformatf("pslverr_o at offset %0d", off));
      end
      "evt":  check_bit(event_line, exp[0], "event_o");
      "txl":  check_bit(tx_line, exp[0], "tx_o");
      "send": send_bytes(int'(data));
      "recv": recv_bytes(int'(data));
      "inj":  inject_frame(data, exp[0]);
      "wait": wait_lsr(data, exp, "the LSR status named in the stimulus file");
      "loop": begin
        @(posedge CLK);
        #2;
        loop_mode = data[0];
      end
      default: abort_run($sformatf("unknown stimulus op %0s", op));
    endcase
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [63:0] op;
    logic [7:0]  off;
    logic [7:0]  data;
    logic [7:0]  exp;
    CLK         = 1'b0;
    RSTN        = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pwrite      = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    loop_mode   = 1'b0;
    inj_line    = 1'b1;                 // idle line
    lcr_sh      = '0;
    dll_sh      = '0;
    dlm_sh      = '0;
    check_count = 0;
    void'($urandom(52));
    repeat (10) @(posedge CLK);
    #2;
    RSTN = 1'b1;

    fd = $fopen("bench/uart_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file bench/uart_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
      fields = $sscanf(line, "%s %h %h %h", op, off, data, exp);
      if (fields != 4) begin
        abort_run($sformatf("malformed stimulus line: %s", line));
      end
      run_op(op, off, data, exp);
    end
    $fclose(fd);

    if (check_count > 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("the stimulus file held no checks");
      $display("TB FAILED");
      $fatal(1, "run stopped");
    end
  end

endmodule

// ==== hdl/uart_apb.sv ====
/*
 * uart top with APB register file
 * DLAB-switched divisor latch, IER, LCR, FCR and LSR,
 * TX/RX FIFO control and prioritized IIR with one event line,
 * holds both shift engines and their FIFOs
 */
`timescale 1ns/1ns

module uart_apb (
  input  logic                                 CLK,
  input  logic                                 RSTN,
  input  logic [uart_reg_pkg::REG_ADDR_W-1:0]  paddr_i,
  input  logic [7:0]                           pwdata_i,
  input  logic                                 pwrite_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  output logic [7:0]                           prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  input  logic                                 rx_i,
  output logic                                 tx_o,
  output logic                                 event_o
);

  logic [7:0] lcr_q, dll_q, dlm_q, lsr_q, lsr_n;
  logic [2:0] ier_q;
  logic [3:0] iir_q, iir_n;
  uart_line_pkg::trig_t trig_q;
  logic oe_q, thre_pend_q, tx_empty_q;
  logic wr_en, rd_en, dlab, lsr_rd, iir_rd;
  logic tx_push, tx_clr, rx_clr, rx_pop;
  uart_line_pkg::line_cfg_t cfg;
  uart_line_pkg::div_t divisor;
  logic tx_valid, tx_ready, tx_empty;
  uart_line_pkg::char_t tx_data;
  logic rx_valid, rx_push_ready, rx_head_valid;
  uart_line_pkg::rx_word_t rx_word, rx_head;
  logic [uart_line_pkg::FIFO_CNT_W-1:0] tx_cnt, rx_cnt, trig_lvl;
  logic int_rls, int_rda, int_thre;

  ////////////////////////////////////////////////////
  // APB decode, no wait states
  assign pready_o  = psel_i;
  assign wr_en     = psel_i & penable_i & pwrite_i;
  assign rd_en     = psel_i & penable_i & ~pwrite_i;
  assign pslverr_o = psel_i & penable_i & ~((paddr_i == uart_reg_pkg::ADR_RBR_THR) |
                     (paddr_i == uart_reg_pkg::ADR_IER) | (paddr_i == uart_reg_pkg::ADR_LCR) |
                     (paddr_i == uart_reg_pkg::ADR_IIR_FCR) | (paddr_i == uart_reg_pkg::ADR_LSR));
  assign dlab    = lcr_q[uart_reg_pkg::LCR_DLAB];
  assign tx_push = wr_en & (paddr_i == uart_reg_pkg::ADR_RBR_THR) & ~dlab; // dropped if full
  assign rx_pop  = rd_en & (paddr_i == uart_reg_pkg::ADR_RBR_THR) & ~dlab;
  assign rx_clr  = wr_en & (paddr_i == uart_reg_pkg::ADR_IIR_FCR) & pwdata_i[1];
  assign tx_clr  = wr_en & (paddr_i == uart_reg_pkg::ADR_IIR_FCR) & pwdata_i[2];
  assign lsr_rd  = rd_en & (paddr_i == uart_reg_pkg::ADR_LSR);
  assign iir_rd  = rd_en & (paddr_i == uart_reg_pkg::ADR_IIR_FCR);

  assign cfg = '{wlen: lcr_q[uart_reg_pkg::LCR_BITS +: 2], pen: lcr_q[uart_reg_pkg::LCR_PEN],
                 eps: lcr_q[uart_reg_pkg::LCR_EPS], stb: lcr_q[uart_reg_pkg::LCR_STOP]};
  assign divisor = {dlm_q, dll_q};

  ////////////////////////////////////////////////////
  // paths
  uart_fifo #(.payload_t(uart_line_pkg::char_t)) u_tx_fifo (
    .CLK(CLK), .RSTN(RSTN), .clr_i(tx_clr),
    .push_valid_i(tx_push), .push_data_i(pwdata_i), .push_ready_o(),
    .pop_valid_o(tx_valid), .pop_data_o(tx_data), .pop_ready_i(tx_ready), .count_o(tx_cnt)
  );
  uart_tx u_tx (
    .CLK(CLK), .RSTN(RSTN), .cfg_i(cfg), .div_i(divisor),
    .tx_valid_i(tx_valid), .tx_data_i(tx_data), .tx_ready_o(tx_ready), .tx_o(tx_o)
  );
  uart_rx u_rx (
    .CLK(CLK), .RSTN(RSTN), .rx_i(rx_i), .cfg_i(cfg), .div_i(divisor),
    .rx_valid_o(rx_valid), .rx_word_o(rx_word), .rx_ready_i(rx_push_ready)
  );
  uart_fifo #(.payload_t(uart_line_pkg::rx_word_t)) u_rx_fifo (
    .CLK(CLK), .RSTN(RSTN), .clr_i(rx_clr),
    .push_valid_i(rx_valid), .push_data_i(rx_word), .push_ready_o(rx_push_ready),
    .pop_valid_o(rx_head_valid), .pop_data_o(rx_head), .pop_ready_i(rx_pop), .count_o(rx_cnt)
  );

  ////////////////////////////////////////////////////
  // status and interrupts
  assign tx_empty = (tx_cnt == '0);

  always_comb begin
    lsr_n = '0;
    lsr_n[uart_reg_pkg::LSR_DR]   = rx_head_valid;
    lsr_n[uart_reg_pkg::LSR_OE]   = oe_q;
    lsr_n[uart_reg_pkg::LSR_PE]   = rx_head_valid & rx_head.perr;  // head entry only
    lsr_n[uart_reg_pkg::LSR_THRE] = tx_empty;
    lsr_n[uart_reg_pkg::LSR_TEMT] = tx_empty & tx_ready;          // shifter idle too
    case (trig_q)
      2'd0:    trig_lvl = 5'd1;
      2'd1:    trig_lvl = 5'd4;
      2'd2:    trig_lvl = 5'd8;
      default: trig_lvl = 5'd14;
    endcase
  end

  assign int_rls  = ier_q[uart_reg_pkg::IER_RLS] & lsr_n[uart_reg_pkg::LSR_PE];
  assign int_rda  = ier_q[uart_reg_pkg::IER_RDA] & (rx_cnt >= trig_lvl);
  assign int_thre = ier_q[uart_reg_pkg::IER_THRE] & thre_pend_q;
  assign event_o  = int_rls | int_rda | int_thre;
  assign iir_n    = int_rls ? uart_reg_pkg::IIR_RLS : int_rda ? uart_reg_pkg::IIR_RDA :
                    int_thre ? uart_reg_pkg::IIR_THRE : uart_reg_pkg::IIR_NONE;

  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (paddr_i)
        uart_reg_pkg::ADR_RBR_THR: prdata_o = dlab ? dll_q : rx_head.data;
        uart_reg_pkg::ADR_IER:     prdata_o = dlab ? dlm_q : {5'b00000, ier_q};
        uart_reg_pkg::ADR_IIR_FCR: prdata_o = {4'hc, iir_q};     // FIFOs always on
        uart_reg_pkg::ADR_LCR:     prdata_o = lcr_q;
        uart_reg_pkg::ADR_LSR:     prdata_o = lsr_q;
        default:                   prdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      lcr_q <= '0; dll_q <= '0; dlm_q <= '0; ier_q <= '0; trig_q <= '0;
      lsr_q <= uart_reg_pkg::LSR_RESET;
      iir_q <= uart_reg_pkg::IIR_RESET;
      oe_q        <= 1'b0;
      thre_pend_q <= 1'b0;
      tx_empty_q  <= 1'b1;
    end else begin
      lsr_q      <= lsr_n;
      iir_q      <= iir_n;
      tx_empty_q <= tx_empty;
      if (rx_valid && !rx_push_ready) oe_q <= 1'b1;              // RX FIFO full
      else if (lsr_rd) oe_q <= 1'b0;
      if (tx_empty && !tx_empty_q) thre_pend_q <= 1'b1;          // FIFO just drained
      else if (iir_rd || tx_push) thre_pend_q <= 1'b0;
      if (wr_en) begin
        case (paddr_i)
          uart_reg_pkg::ADR_RBR_THR: if (dlab) dll_q <= pwdata_i;
          uart_reg_pkg::ADR_IER: begin
            if (dlab) dlm_q <= pwdata_i;
            else ier_q <= pwdata_i[2:0];
          end
          uart_reg_pkg::ADR_IIR_FCR: trig_q <= pwdata_i[7:6];   // clears decoded above
          uart_reg_pkg::ADR_LCR:     lcr_q  <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== hdl/uart_fifo.sv ====
/*
 * uart FIFO
 * synchronous circular buffer with a clear and an entry count,
 * valid/ready on both sides, payload set by a type parameter
 */
`timescale 1ns/1ns

module uart_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                                 CLK,
  input  logic                                 RSTN,
  input  logic                                 clr_i,        // empties in one cycle
  input  logic                                 push_valid_i,
  input  payload_t                             push_data_i,
  output logic                                 push_ready_o,
  output logic                                 pop_valid_o,
  output payload_t                             pop_data_o,
  input  logic                                 pop_ready_i,
  output logic [uart_line_pkg::FIFO_CNT_W-1:0] count_o
);

  // pointers carry a wrap bit above the index
  logic [uart_line_pkg::FIFO_CNT_W-1:0] wr_ptr;
  logic [uart_line_pkg::FIFO_CNT_W-1:0] rd_ptr;
  payload_t                             mem [uart_line_pkg::FIFO_DEPTH];
  logic                                 push;
  logic                                 pop;

  // full when indexes match and wrap bits differ
  assign push_ready_o = (wr_ptr != {~rd_ptr[uart_line_pkg::FIFO_CNT_W-1],
                                    rd_ptr[uart_line_pkg::FIFO_CNT_W-2:0]});
  assign pop_valid_o  = (wr_ptr != rd_ptr);
  assign count_o      = wr_ptr - rd_ptr;
  assign pop_data_o   = mem[rd_ptr[uart_line_pkg::FIFO_CNT_W-2:0]];

  assign push = push_valid_i & push_ready_o & ~clr_i;   // clear wins over push
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge CLK) begin
    if (push) mem[wr_ptr[uart_line_pkg::FIFO_CNT_W-2:0]] <= push_data_i;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== hdl/uart_line_pkg.sv ====
/*
 * uart line format
 * character and receive word types, divisor and frame
 * configuration, FIFO sizing and RX trigger code
 */
package uart_line_pkg;

  typedef logic [7:0] char_t;

  // receive word as stored in the RX FIFO
  typedef struct packed {
    logic  perr;                  // parity mismatch on this character
    char_t data;
  } rx_word_t;

  typedef logic [15:0] div_t;     // clocks per bit, 2 or more

  typedef struct packed {
    logic [1:0] wlen;             // data bits - 5
    logic       pen;              // parity enable
    logic       eps;              // 1: even, 0: odd
    logic       stb;              // 1: two stop bits
  } line_cfg_t;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_CNT_W = 5;  // 0..16 entries

  typedef logic [1:0] trig_t;     // RX trigger 1/4/8/14

endpackage

// ==== hdl/uart_reg_pkg.sv ====
/*
 * uart register map
 * offsets, bit positions inside LCR, LSR and IER,
 * IIR identification codes and register reset values
 */
package uart_reg_pkg;

  localparam int REG_ADDR_W = 3;                        // byte offsets 0..7

  // register offsets, 4/6/7 are not implemented
  localparam logic [REG_ADDR_W-1:0] ADR_RBR_THR = 3'd0; // DLL when DLAB set
  localparam logic [REG_ADDR_W-1:0] ADR_IER     = 3'd1; // DLM when DLAB set
  localparam logic [REG_ADDR_W-1:0] ADR_IIR_FCR = 3'd2; // IIR on read, FCR on write
  localparam logic [REG_ADDR_W-1:0] ADR_LCR     = 3'd3;
  localparam logic [REG_ADDR_W-1:0] ADR_LSR     = 3'd5;

  // LCR fields
  localparam int LCR_BITS = 0;                          // 2 bits, word length - 5
  localparam int LCR_STOP = 2;                          // 0: 1 stop, 1: 2 stop
  localparam int LCR_PEN  = 3;
  localparam int LCR_EPS  = 4;                          // even parity select
  localparam int LCR_DLAB = 7;

  // LSR fields
  localparam int LSR_DR   = 0;
  localparam int LSR_OE   = 1;
  localparam int LSR_PE   = 2;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  // IER fields
  localparam int IER_RDA  = 0;
  localparam int IER_THRE = 1;
  localparam int IER_RLS  = 2;

  // IIR codes, highest priority first
  localparam logic [3:0] IIR_RLS  = 4'h6;
  localparam logic [3:0] IIR_RDA  = 4'h4;
  localparam logic [3:0] IIR_THRE = 4'h2;
  localparam logic [3:0] IIR_NONE = 4'h1;               // bit 0 set, nothing pending

  localparam logic [7:0] LSR_RESET = 8'h60;             // THRE and TEMT
  localparam logic [3:0] IIR_RESET = 4'h1;

endpackage

// ==== hdl/uart_rx.sv ====
/*
 * uart receiver
 * synchronizes the line, qualifies the start bit at half a bit,
 * samples data and parity mid-bit and offers each character
 * with a parity-error flag at mid stop bit, never stalling
 */
`timescale 1ns/1ns

module uart_rx (
  input  logic                      CLK,
  input  logic                      RSTN,
  input  logic                      rx_i,
  input  uart_line_pkg::line_cfg_t  cfg_i,
  input  uart_line_pkg::div_t       div_i,
  output logic                      rx_valid_o,
  output uart_line_pkg::rx_word_t   rx_word_o,
  input  logic                      rx_ready_i
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e            state;
  logic                 rx_q1;
  logic                 rx_s;       // synchronized line
  logic                 rx_prev;    // for edge detect
  uart_line_pkg::div_t  baud;
  logic [3:0]           idx;        // data bits then parity
  logic [3:0]           nbits;
  logic [3:0]           last_idx;
  uart_line_pkg::char_t data;
  logic                 par_bit;
  logic                 par_calc;
  logic                 start_ok;
  logic                 sample;
  logic                 stop_mid;

  assign nbits    = 4'd5 + {2'b00, cfg_i.wlen};
  assign last_idx = nbits + {3'b000, cfg_i.pen} - 4'd1;
  assign par_calc = ^data ^ ~cfg_i.eps;                  // bits above length are 0

  assign start_ok = (state == RX_START) && (baud == '0) && !rx_s;
  assign sample   = (state == RX_DATA) && (baud == '0);
  assign stop_mid = (state == RX_STOP) && (baud == '0);

  ////////////////////////////////////////////////////
  // character assembly

  always_ff @(posedge CLK) begin
    if (start_ok) data <= '0;
    else if (sample && (idx < nbits)) data[idx[2:0]] <= rx_s;
    if (sample && (idx == nbits)) par_bit <= rx_s;       // only reached with parity
    if (stop_mid) begin
      rx_word_o.perr <= cfg_i.pen & (par_bit != par_calc);
      rx_word_o.data <= data;
    end
  end

  ////////////////////////////////////////////////////
  // bit timing FSM

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      rx_q1      <= 1'b1;
      rx_s       <= 1'b1;
      rx_prev    <= 1'b1;
      state      <= RX_IDLE;
      baud       <= '0;
      idx        <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_q1   <= rx_i;
      rx_s    <= rx_q1;
      rx_prev <= rx_s;
      if (rx_valid_o && rx_ready_i) rx_valid_o <= 1'b0;
      case (state)
        RX_IDLE: if (rx_prev && !rx_s) begin            // falling edge
          state <= RX_START;
          baud  <= {1'b0, div_i[15:1]} - 16'd1;          // half a bit
        end
        RX_START: if (baud == '0) begin
          if (!rx_s) begin
            state      <= RX_DATA;
            baud       <= div_i - 16'd1;
            idx        <= '0;
            rx_valid_o <= 1'b0;                          // unclaimed word is lost
          end else begin
            state <= RX_IDLE;                            // glitch
          end
        end else baud <= baud - 16'd1;
        RX_DATA: if (baud == '0) begin
          baud <= div_i - 16'd1;
          idx  <= idx + 4'd1;
          if (idx == last_idx) state <= RX_STOP;
        end else baud <= baud - 16'd1;
        default: if (baud == '0) begin                   // mid stop bit
          state      <= RX_IDLE;
          rx_valid_o <= 1'b1;
        end else baud <= baud - 16'd1;
      endcase
    end
  end

endmodule

// ==== hdl/uart_tx.sv ====
/*
 * uart transmitter
 * takes one character per valid/ready transfer while idle and
 * shifts out start, data LSB first, optional parity and stop bits
 */
`timescale 1ns/1ns

module uart_tx (
  input  logic                      CLK,
  input  logic                      RSTN,
  input  uart_line_pkg::line_cfg_t  cfg_i,
  input  uart_line_pkg::div_t       div_i,
  input  logic                      tx_valid_i,
  input  uart_line_pkg::char_t      tx_data_i,
  output logic                      tx_ready_o,
  output logic                      tx_o
);

  logic                 busy;
  uart_line_pkg::div_t  baud;       // clocks left in this bit
  logic [3:0]           bits_left;  // frame bits still to send
  logic [11:0]          shreg;      // bit 0 drives the line
  logic [11:0]          frame;
  logic [3:0]           nbits;
  logic [3:0]           nframe;
  uart_line_pkg::char_t data_m;
  logic                 parity;

  // frame for the character at the FIFO head
  always_comb begin
    nbits  = 4'd5 + {2'b00, cfg_i.wlen};
    nframe = 4'd7 + {2'b00, cfg_i.wlen} + {3'b000, cfg_i.pen} + {3'b000, cfg_i.stb};
    data_m = tx_data_i & (8'hff >> (2'd3 - cfg_i.wlen));  // drop bits above length
    parity = ^data_m ^ ~cfg_i.eps;
    frame    = '1;                                         // stop bits and idle
    frame[0] = 1'b0;                                       // start
    for (int i = 0; i < 8; i++) begin
      if (i < nbits) frame[i+1] = data_m[i];
    end
    if (cfg_i.pen) frame[nbits+1] = parity;
  end

  assign tx_ready_o = ~busy;
  assign tx_o       = shreg[0];

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      busy      <= 1'b0;
      baud      <= '0;
      bits_left <= '0;
      shreg     <= '1;                  // line idles high
    end else if (!busy) begin
      if (tx_valid_i) begin             // transfer, start bit from next cycle
        busy      <= 1'b1;
        shreg     <= frame;
        baud      <= div_i - 16'd1;
        bits_left <= nframe;
      end
    end else if (baud == '0) begin      // bit period over
      shreg     <= {1'b1, shreg[11:1]};
      baud      <= div_i - 16'd1;
      bits_left <= bits_left - 4'd1;
      if (bits_left == 4'd1) busy <= 1'b0;  // last stop bit done
    end else begin
      baud <= baud - 16'd1;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the UART testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module uart_tb -f sim.f -o uart_sim \
  && ./obj_dir/uart_sim \
  || exit 1

// ==== sim.f ====
hdl/uart_line_pkg.sv
hdl/uart_reg_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_apb.sv
bench/uart_tb.sv
